//--- verilog/nabp_pkg.sv
package nabp_pkg;

    // one filtered projection sample
    typedef logic [15:0] sample_t;

    // unsigned fixed point, 1 integer bit and 8 fraction bits
    typedef logic [8:0] accu_t;

    localparam int accu_frac_width = 8;

    // shifter phases
    typedef enum logic [1:0] {
        ready_s,
        fill_s,
        fill_done_s,
        shift_s
    } shifter_state_t;

    // line sequencing
    // prefixed so the labels stay apart from the shifter ones in this scope
    typedef enum logic [1:0] {
        seq_idle_s,
        seq_fill_s,
        seq_shift_s,
        seq_done_s
    } sequencer_state_t;

endpackage

//--- verilog/shift_ctrl_if.sv
interface shift_ctrl_if;

    // kicks from the sequencer, one cycle each
    logic fill_kick;
    logic shift_kick;

    // done pulses from the shifter at the end of each phase
    logic fill_done;
    logic shift_done;

    modport control
    (
        output fill_kick,
        output shift_kick,
        input  fill_done,
        input  shift_done
    );

    modport shifter
    (
        input  fill_kick,
        input  shift_kick,
        output fill_done,
        output shift_done
    );

endinterface

//--- verilog/nabp_sequencer.sv
module nabp_sequencer
    import nabp_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start,
    input  accu_t                slope,
    output logic                 busy,
    output logic                 line_done,
    output accu_t                line_slope,
    shift_ctrl_if.control        ctrl
);

    sequencer_state_t state;

    // slope for the whole line, captured on an accepted start
    always_ff @(posedge clk)
    begin
        if (state == seq_idle_s && start)
            line_slope <= slope;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state           <= seq_idle_s;
            ctrl.fill_kick  <= 1'b0;
            ctrl.shift_kick <= 1'b0;
        end
        else
        begin
            // kicks are single cycle
            ctrl.fill_kick  <= 1'b0;
            ctrl.shift_kick <= 1'b0;

            case (state)
                seq_idle_s:
                begin
                    if (start)
                    begin
                        ctrl.fill_kick <= 1'b1;
                        state          <= seq_fill_s;
                    end
                end
                seq_fill_s:
                begin
                    // window is full, start walking the row
                    if (ctrl.fill_done)
                    begin
                        ctrl.shift_kick <= 1'b1;
                        state           <= seq_shift_s;
                    end
                end
                seq_shift_s:
                begin
                    if (ctrl.shift_done)
                        state <= seq_done_s;
                end
                seq_done_s:
                begin
                    state <= seq_idle_s;
                end
                default:
                begin
                    state <= seq_idle_s;
                end
            endcase
        end
    end

    // start is only taken in idle, so busy covers every other state
    assign busy = (state != seq_idle_s);

    // one cycle in done_s gives the completion pulse
    assign line_done = (state == seq_done_s);

endmodule

//--- verilog/nabp_shifter.sv
module nabp_shifter
    import nabp_pkg::*;
#(
    parameter int image_size = 8,
    parameter int fill_depth = 4
)
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  accu_t                line_slope,
    shift_ctrl_if.shifter        ctrl,
    output logic                 shift_enable,
    output logic                 column_strobe
);

    localparam int fill_cnt_width  = $clog2(fill_depth + 1);
    localparam int shift_cnt_width = $clog2(image_size + 1);

    // counters run down to zero, so they start one below the count
    localparam logic [fill_cnt_width-1:0] fill_cnt_init =
        fill_cnt_width'(fill_depth - 1);
    localparam logic [shift_cnt_width-1:0] shift_cnt_init =
        shift_cnt_width'(image_size - 1);

    shifter_state_t state;
    shifter_state_t next_state;

    logic [fill_cnt_width-1:0]  fill_cnt;
    logic [shift_cnt_width-1:0] shift_cnt;

    // accu holds k * slope during shift cycle k
    accu_t accu;
    accu_t accu_step;

    // mealy done pulses from the counters
    assign ctrl.fill_done  = (state == fill_s) && (fill_cnt == '0);
    assign ctrl.shift_done = (state == shift_s) && (shift_cnt == '0);

    assign column_strobe = (state == shift_s);

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (ctrl.fill_kick)
                    next_state = fill_s;
            fill_s:
                if (ctrl.fill_done)
                    next_state = fill_done_s;
            fill_done_s:
                if (ctrl.shift_kick)
                    next_state = shift_s;
            shift_s:
                if (ctrl.shift_done)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // accu sits at zero outside the shift phase, so a line starts from zero
    assign accu_step = accu + line_slope;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= ready_s;
        else
            state <= next_state;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_cnt     <= fill_cnt_init;
            shift_cnt    <= shift_cnt_init;
            accu         <= '0;
            shift_enable <= 1'b0;
        end
        else
        begin
            if (state == fill_s && fill_cnt != '0)
                fill_cnt <= fill_cnt - 1'b1;
            else
                fill_cnt <= fill_cnt_init;

            if (state == shift_s && shift_cnt != '0)
                shift_cnt <= shift_cnt - 1'b1;
            else
                shift_cnt <= shift_cnt_init;

            // the integer bit may wrap, only its flips mark a boundary
            shift_enable <= 1'b0;
            if (next_state == fill_s)
            begin
                shift_enable <= 1'b1;
            end
            else if (next_state == shift_s)
            begin
                shift_enable <= accu_step[accu_frac_width] ^ accu[accu_frac_width];
            end

            if (next_state == shift_s)
                accu <= accu_step;
            else
                accu <= '0;
        end
    end

endmodule

//--- verilog/nabp_filter_mapper.sv
module nabp_filter_mapper
    import nabp_pkg::*;
#(
    parameter int fill_depth = 4
)
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    shift_enable,
    input  logic    column_strobe,
    input  sample_t sample_in,
    output logic    mapped_valid,
    output sample_t mapped_sample
);

    // slot 0 is newest, slot fill_depth - 1 is oldest
    sample_t window      [fill_depth];
    sample_t window_next [fill_depth];

    always_comb
    begin
        window_next = window;
        if (shift_enable)
        begin
            window_next[0] = sample_in;
            for (int i = 1; i < fill_depth; i++)
                window_next[i] = window[i - 1];
        end
    end

    always_ff @(posedge clk)
    begin
        window <= window_next;
    end

    // oldest slot as it stands after this cycle's shift
    always_ff @(posedge clk)
    begin
        if (column_strobe)
            mapped_sample <= window_next[fill_depth - 1];
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            mapped_valid <= 1'b0;
        else
            mapped_valid <= column_strobe;
    end

endmodule

//--- verilog/nabp_shift_unit.sv
module nabp_shift_unit
    import nabp_pkg::*;
#(
    parameter int image_size = 8,
    parameter int fill_depth = 4
)
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    start,
    input  accu_t   slope,
    input  sample_t sample_in,
    output logic    sample_take,
    output logic    mapped_valid,
    output sample_t mapped_sample,
    output logic    busy,
    output logic    line_done
);

    accu_t line_slope;
    logic  column_strobe;

    shift_ctrl_if ctrl_if ();

    nabp_sequencer sequencer0
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (start),
        .slope      (slope),
        .busy       (busy),
        .line_done  (line_done),
        .line_slope (line_slope),
        .ctrl       (ctrl_if.control)
    );

    // shift_enable doubles as the take strobe for the sample source
    nabp_shifter #(
        .image_size (image_size),
        .fill_depth (fill_depth)
    ) shifter0
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .line_slope    (line_slope),
        .ctrl          (ctrl_if.shifter),
        .shift_enable  (sample_take),
        .column_strobe (column_strobe)
    );

    nabp_filter_mapper #(
        .fill_depth (fill_depth)
    ) mapper0
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .shift_enable  (sample_take),
        .column_strobe (column_strobe),
        .sample_in     (sample_in),
        .mapped_valid  (mapped_valid),
        .mapped_sample (mapped_sample)
    );

endmodule

//--- test/nabp_shift_unit_tb.sv
module nabp_shift_unit_tb
    import nabp_pkg::*;
();

    localparam int image_size   = 8;
    localparam int fill_depth   = 4;
    localparam int frac_bits    = 8;
    localparam int line_timeout = 200;

    logic    clk;
    logic    reset_n;
    logic    start;
    accu_t   slope;
    sample_t sample_in;
    logic    sample_take;
    logic    mapped_valid;
    sample_t mapped_sample;
    logic    busy;
    logic    line_done;

    integer  seed;
    int      errors;
    int      timeouts;
    int      line_dones;
    int      line_takes;
    int      line_outputs;
    logic    take_pending;
    sample_t line_base;
    accu_t   cur_slope;

    nabp_shift_unit dut0
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .start         (start),
        .slope         (slope),
        .sample_in     (sample_in),
        .sample_take   (sample_take),
        .mapped_valid  (mapped_valid),
        .mapped_sample (mapped_sample),
        .busy          (busy),
        .line_done     (line_done)
    );

    always #10 clk = ~clk;

    // window holds fill_depth samples, then one more per boundary crossing
    function automatic sample_t expected_sample(sample_t base, accu_t slope_val, int k);
        int shifts;
        shifts = fill_depth + ((k * slope_val) >> frac_bits);
        return base + sample_t'(shifts - fill_depth);
    endfunction

    function automatic int expected_takes(accu_t slope_val);
        return fill_depth + ((image_size * slope_val) >> frac_bits);
    endfunction

    // sample source and output checker, all on the falling edge
    always @(negedge clk)
    begin
        if (take_pending)
            sample_in = sample_in + 1'b1;
        take_pending = sample_take;
        if (sample_take)
            line_takes++;
        if (mapped_valid)
        begin
            line_outputs++;
            assert (mapped_sample == expected_sample(line_base, cur_slope, line_outputs))
            else
            begin
                errors++;
                $display("error: %0t: column %0d gave %h, expected %h", $time, line_outputs,
                         mapped_sample, expected_sample(line_base, cur_slope, line_outputs));
            end
        end
        if (line_done)
        begin
            assert (line_outputs == image_size)
            else
            begin
                errors++;
                $display("error: %0t: %0d outputs in line, expected %0d", $time,
                         line_outputs, image_size);
            end
            assert (line_takes == expected_takes(cur_slope))
            else
            begin
                errors++;
                $display("error: %0t: %0d samples taken, expected %0d", $time,
                         line_takes, expected_takes(cur_slope));
            end
            line_dones++;
            line_takes   = 0;
            line_outputs = 0;
        end
    end

    task automatic run_line(input accu_t slope_val, input logic stray_start);
        int   dones_before;
        int   cycles;
        logic seen;
        dones_before = line_dones;
        @(negedge clk);
        start     = 1'b1;
        slope     = slope_val;
        cur_slope = slope_val;
        // source value at the start of the line is its first sample
        line_base = sample_in;
        @(negedge clk);
        start = 1'b0;
        if (stray_start)
        begin
            repeat (3) @(negedge clk);
            // second start mid line, different slope
            start = 1'b1;
            slope = ~slope_val & 9'h0ff;
            @(negedge clk);
            start = 1'b0;
        end
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < line_timeout)
        begin
            @(negedge clk);
            seen = line_done;
            cycles++;
            assert (busy)
            else
            begin
                errors++;
                $display("error: %0t: busy low while the line runs", $time);
            end
        end
        if (!seen)
        begin
            timeouts++;
            $display("timed out waiting for line_done, slope %h", slope_val);
        end
        @(negedge clk);
        assert (!busy)
        else
        begin
            errors++;
            $display("error: %0t: busy still high after line_done", $time);
        end
        // leave room for a second line to appear
        repeat (image_size + fill_depth + 4) @(negedge clk);
        assert (line_dones == dones_before + 1)
        else
        begin
            errors++;
            $display("error: %0t: %0d line_done pulses, expected 1", $time,
                     line_dones - dones_before);
        end
    endtask

    initial
    begin
        clk          = 1'b0;
        reset_n      = 1'b0;
        start        = 1'b0;
        slope        = '0;
        sample_in    = 16'h0100;
        seed         = 32'hf563;
        errors       = 0;
        timeouts     = 0;
        line_dones   = 0;
        line_takes   = 0;
        line_outputs = 0;
        take_pending = 1'b0;
        line_base    = '0;
        cur_slope    = '0;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        repeat (3)
        begin
            @(negedge clk);
            assert (!busy && !line_done && !mapped_valid && !sample_take)
            else
            begin
                errors++;
                $display("error: %0t: outputs active before any start", $time);
            end
        end
        run_line(9'h000, 1'b0);
        run_line(9'h080, 1'b0);
        for (int i = 0; i < 20; i++)
            run_line(accu_t'($random(seed) & 32'hff), 1'b0);
        run_line(9'h0c0, 1'b1);
        $display("errors %0d, timeouts %0d, lines %0d", errors, timeouts, line_dones);
        if (errors == 0 && timeouts == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- nabp_shift_unit.f
verilog/nabp_pkg.sv
verilog/shift_ctrl_if.sv
verilog/nabp_sequencer.sv
verilog/nabp_shifter.sv
verilog/nabp_filter_mapper.sv
verilog/nabp_shift_unit.sv
test/nabp_shift_unit_tb.sv

//--- Bender.yml
package:
  name: nabp_shift_unit

sources:
  - verilog/nabp_pkg.sv
  - verilog/shift_ctrl_if.sv
  - verilog/nabp_sequencer.sv
  - verilog/nabp_shifter.sv
  - verilog/nabp_filter_mapper.sv
  - verilog/nabp_shift_unit.sv
  - target: test
    files:
      - test/nabp_shift_unit_tb.sv
